// ==== logic/rv_backend_pkg.sv ====
`default_nettype none

package rv_backend_pkg;

  //////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Stage PC after reset
  localparam logic [XLEN-1:0] PC_INIT = 'h200;

  //////////////////////////////////////////////////
  // Instruction decode
  //////////////////////////////////////////////////

  // Major opcodes handled by the back end
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  // Both ALU forms write rd and never touch memory
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Access size in funct3 of loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  //////////////////////////////////////////////////
  // Exceptions
  //////////////////////////////////////////////////

  // Exception vector travelling with each instruction
  localparam int unsigned EXC_W           = 3;
  localparam int unsigned EXC_ILLEGAL     = 0;
  localparam int unsigned EXC_LD_MISALIGN = 1;
  localparam int unsigned EXC_ST_MISALIGN = 2;

  // mcause codes reported with a trap
  localparam logic [XLEN-1:0] CAUSE_ILLEGAL     = 'd2;
  localparam logic [XLEN-1:0] CAUSE_LD_MISALIGN = 'd4;
  localparam logic [XLEN-1:0] CAUSE_ST_MISALIGN = 'd6;

  // Data-bus master phases
  localparam logic [1:0] LSU_IDLE = 2'd0;
  localparam logic [1:0] LSU_REQ  = 2'd1;
  // req dropped, waiting for ack to fall
  localparam logic [1:0] LSU_WAIT = 2'd2;
  localparam logic [1:0] LSU_DONE = 2'd3;

  // Instruction word, I-type and S-type layouts over the same 32 bits
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_view;
  } insn_u;

endpackage

`default_nettype wire

// ==== logic/stage_if.sv ====
`default_nettype none

// Contents of one pipeline stage, memory stage to write-back
interface stage_if;

  logic [rv_backend_pkg::XLEN-1:0]  pc;
  rv_backend_pkg::insn_u            insn;
  // High when the stage holds no valid instruction
  logic                             bubble;
  // ALU result
  logic [rv_backend_pkg::XLEN-1:0]  r;
  logic [rv_backend_pkg::XLEN-1:0]  memadr;
  logic [rv_backend_pkg::EXC_W-1:0] exc;

  // Memory stage side
  modport src (
    output pc,
    output insn,
    output bubble,
    output r,
    output memadr,
    output exc
  );

  // Write-back side
  modport dst (
    input pc,
    input insn,
    input bubble,
    input r,
    input memadr,
    input exc
  );

endinterface

`default_nettype wire

// ==== logic/mem_stage.sv ====
`default_nettype none

module mem_stage (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             stall_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  pc_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  r_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  memadr_i,
  input  rv_backend_pkg::insn_u            insn_i,
  input  logic                             bubble_i,
  input  logic [rv_backend_pkg::EXC_W-1:0] exc_dn_i,
  input  logic                             flush_i,
  stage_if.src                             st
);

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  // Program counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st.pc <= rv_backend_pkg::PC_INIT;
    end else if (!stall_i) begin
      st.pc <= pc_i;
    end
  end

  // Instruction word, result and address
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      st.insn   <= insn_i;
      st.r      <= r_i;
      st.memadr <= memadr_i;
    end
  end

  // Bubble
  // Flush from write-back kills whatever sits here, even under stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st.bubble <= 1'b1;
    end else if (flush_i) begin
      st.bubble <= 1'b1;
    end else if (!stall_i) begin
      st.bubble <= bubble_i;
    end
  end

  //////////////////////////////////////////////////
  // Exceptions going down
  //////////////////////////////////////////////////

  // Execute-side bits merged with LSU misalignment bits
  // Cleared when an earlier exception flushes the pipe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st.exc <= '0;
    end else if (flush_i) begin
      st.exc <= '0;
    end else if (!stall_i) begin
      st.exc <= exc_dn_i;
    end
  end

  // Killed instruction never reaches write-back as valid
  a_flush_bubbles: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> st.bubble)
    else $error("mem_stage: bubble not set after flush");

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`default_nettype none

module load_store_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  rv_backend_pkg::insn_u            insn_i,
  input  logic                             bubble_i,
  input  logic [rv_backend_pkg::EXC_W-1:0] exc_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  adr_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  wdata_i,
  input  logic                             flush_i,
  output logic                             busy_o,
  output logic [rv_backend_pkg::EXC_W-1:0] exc_o,
  output logic [rv_backend_pkg::XLEN-1:0]  ldata_o,
  output logic                             dbus_req_o,
  output logic                             dbus_we_o,
  output logic [rv_backend_pkg::XLEN-1:0]  dbus_adr_o,
  output logic [3:0]                       dbus_be_o,
  output logic [rv_backend_pkg::XLEN-1:0]  dbus_wdata_o,
  input  logic                             dbus_ack_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  dbus_rdata_i
);

  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic                            is_ld;
  logic                            is_st;
  logic                            misaligned;
  logic                            start;
  logic [rv_backend_pkg::XLEN-1:0] st_off;
  logic [1:0]                      state_q;
  logic [1:0]                      state_d;
  logic [3:0]                      lane_be;
  logic [rv_backend_pkg::XLEN-1:0] lane_wdata;
  logic [rv_backend_pkg::XLEN-1:0] rdata_sh;
  logic [rv_backend_pkg::XLEN-1:0] ld_ext;

  //////////////////////////////////////////////////
  // Decode and alignment check
  //////////////////////////////////////////////////

  // opcode and funct3 sit at the same bits in both views
  assign opcode = insn_i.s_view.opcode;
  assign funct3 = insn_i.s_view.funct3;
  assign is_ld  = opcode == rv_backend_pkg::OPC_LOAD;
  assign is_st  = opcode == rv_backend_pkg::OPC_STORE;

  // S-type offset, sign extended
  assign st_off = {{(rv_backend_pkg::XLEN-12){insn_i.s_view.imm_hi[6]}},
                   insn_i.s_view.imm_hi, insn_i.s_view.imm_lo};

  // Natural alignment by access size
  always_comb begin
    case (funct3)
      rv_backend_pkg::F3_H, rv_backend_pkg::F3_HU: misaligned = adr_i[0];
      rv_backend_pkg::F3_W:                        misaligned = |adr_i[1:0];
      default:                                     misaligned = 1'b0;
    endcase
  end

  // Misaligned accesses report here and never reach the bus
  always_comb begin
    exc_o = exc_i;
    if (!bubble_i && misaligned) begin
      exc_o[rv_backend_pkg::EXC_LD_MISALIGN] = exc_i[rv_backend_pkg::EXC_LD_MISALIGN] | is_ld;
      exc_o[rv_backend_pkg::EXC_ST_MISALIGN] = exc_i[rv_backend_pkg::EXC_ST_MISALIGN] | is_st;
    end
  end

  // Valid aligned access with nothing pending ahead of it
  assign start = !bubble_i && (is_ld || is_st) && !misaligned &&
                 (exc_i == '0) && !flush_i;

  //////////////////////////////////////////////////
  // Four-phase bus master
  //////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      rv_backend_pkg::LSU_IDLE:
        state_d = start ? rv_backend_pkg::LSU_REQ : rv_backend_pkg::LSU_IDLE;
      rv_backend_pkg::LSU_REQ:
        state_d = dbus_ack_i ? rv_backend_pkg::LSU_WAIT : rv_backend_pkg::LSU_REQ;
      rv_backend_pkg::LSU_WAIT:
        state_d = dbus_ack_i ? rv_backend_pkg::LSU_WAIT : rv_backend_pkg::LSU_DONE;
      default:
        state_d = rv_backend_pkg::LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rv_backend_pkg::LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy from the start cycle through the ack-low cycle
  // DONE lets the memory stage take the instruction
  assign busy_o = (state_q == rv_backend_pkg::LSU_IDLE) ? start
                                                        : (state_q != rv_backend_pkg::LSU_DONE);
  assign dbus_req_o = state_q == rv_backend_pkg::LSU_REQ;

  // Byte lanes, data replicated across the word
  always_comb begin
    case (funct3)
      rv_backend_pkg::F3_B, rv_backend_pkg::F3_BU: begin
        lane_be    = 4'b0001 << adr_i[1:0];
        lane_wdata = {4{wdata_i[7:0]}};
      end
      rv_backend_pkg::F3_H, rv_backend_pkg::F3_HU: begin
        lane_be    = 4'b0011 << adr_i[1:0];
        lane_wdata = {2{wdata_i[15:0]}};
      end
      default: begin
        lane_be    = 4'b1111;
        lane_wdata = wdata_i;
      end
    endcase
  end

  // Bus fields held from start until the next access
  always_ff @(posedge clk_i) begin
    if ((state_q == rv_backend_pkg::LSU_IDLE) && start) begin
      dbus_we_o    <= is_st;
      dbus_adr_o   <= {adr_i[rv_backend_pkg::XLEN-1:2], 2'b00};
      dbus_be_o    <= lane_be;
      dbus_wdata_o <= lane_wdata;
    end
  end

  //////////////////////////////////////////////////
  // Load data
  //////////////////////////////////////////////////

  // Addressed byte moved down to bit 0
  assign rdata_sh = dbus_rdata_i >> {adr_i[1:0], 3'b000};

  always_comb begin
    case (funct3)
      rv_backend_pkg::F3_B:
        ld_ext = {{(rv_backend_pkg::XLEN-8){rdata_sh[7]}}, rdata_sh[7:0]};
      rv_backend_pkg::F3_BU:
        ld_ext = {{(rv_backend_pkg::XLEN-8){1'b0}}, rdata_sh[7:0]};
      rv_backend_pkg::F3_H:
        ld_ext = {{(rv_backend_pkg::XLEN-16){rdata_sh[15]}}, rdata_sh[15:0]};
      rv_backend_pkg::F3_HU:
        ld_ext = {{(rv_backend_pkg::XLEN-16){1'b0}}, rdata_sh[15:0]};
      default:
        ld_ext = dbus_rdata_i;
    endcase
  end

  // Sampled at ack rise, kept until the next access
  always_ff @(posedge clk_i) begin
    if ((state_q == rv_backend_pkg::LSU_REQ) && dbus_ack_i) begin
      ldata_o <= ld_ext;
    end
  end

  // Handshake rules
  a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dbus_req_o && dbus_ack_i |=> !dbus_req_o)
    else $error("lsu: req raised before ack fell");

  a_bus_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbus_req_o |=> !dbus_req_o || ($stable(dbus_adr_o) && $stable(dbus_be_o)))
    else $error("lsu: address or byte enables moved during req");

  // Stall must freeze the store at the execute side for the whole access
  a_store_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == rv_backend_pkg::LSU_REQ || state_q == rv_backend_pkg::LSU_WAIT) && is_st
    |-> $stable(adr_i - st_off))
    else $error("lsu: store base changed during access");

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
`default_nettype none

module wb_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  stage_if.dst                            ld,
  input  logic [rv_backend_pkg::XLEN-1:0] ldata_i,
  input  logic                            stall_i,
  output logic                            rf_we_o,
  output logic [4:0]                      rf_waddr_o,
  output logic [rv_backend_pkg::XLEN-1:0] rf_wdata_o,
  output logic                            flush_o,
  output logic                            trap_o,
  output logic [rv_backend_pkg::XLEN-1:0] trap_pc_o,
  output logic [rv_backend_pkg::XLEN-1:0] trap_cause_o
);

  logic [rv_backend_pkg::XLEN-1:0]  pc_q;
  logic [rv_backend_pkg::XLEN-1:0]  r_q;
  logic [rv_backend_pkg::XLEN-1:0]  ldata_q;
  rv_backend_pkg::insn_u            insn_q;
  logic                             bubble_q;
  logic [rv_backend_pkg::EXC_W-1:0] exc_q;
  logic [6:0]                       opc_q;
  logic                             writes_rd;

  // Load data of the instruction now in the memory stage
  // Loads on the same edges as that register, so a following access cannot overwrite it
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      ldata_q <= ldata_i;
    end
  end

  // Result picked per opcode on entry
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      insn_q <= ld.insn;
      r_q    <= (ld.insn.i_view.opcode == rv_backend_pkg::OPC_LOAD) ? ldata_q : ld.r;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q  <= rv_backend_pkg::PC_INIT;
      exc_q <= '0;
    end else if (!stall_i) begin
      pc_q  <= ld.pc;
      exc_q <= ld.exc;
    end
  end

  // A trap retires its instruction, so flush is a single cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
    end else if (flush_o) begin
      bubble_q <= 1'b1;
    end else if (!stall_i) begin
      bubble_q <= ld.bubble;
    end
  end

  //////////////////////////////////////////////////
  // Register file write and trap
  //////////////////////////////////////////////////

  assign opc_q     = insn_q.i_view.opcode;
  assign writes_rd = (opc_q == rv_backend_pkg::OPC_LOAD) ||
                     (opc_q == rv_backend_pkg::OPC_OP)   ||
                     (opc_q == rv_backend_pkg::OPC_OP_IMM);

  // x0 is hardwired, never written
  assign rf_we_o    = !bubble_q && (exc_q == '0) && writes_rd && (insn_q.i_view.rd != 5'd0);
  assign rf_waddr_o = insn_q.i_view.rd;
  assign rf_wdata_o = r_q;

  assign flush_o   = !bubble_q && (|exc_q);
  assign trap_o    = flush_o;
  assign trap_pc_o = pc_q;

  // Illegal beats load misalign beats store misalign
  always_comb begin
    if (exc_q[rv_backend_pkg::EXC_ILLEGAL]) begin
      trap_cause_o = rv_backend_pkg::CAUSE_ILLEGAL;
    end else if (exc_q[rv_backend_pkg::EXC_LD_MISALIGN]) begin
      trap_cause_o = rv_backend_pkg::CAUSE_LD_MISALIGN;
    end else if (exc_q[rv_backend_pkg::EXC_ST_MISALIGN]) begin
      trap_cause_o = rv_backend_pkg::CAUSE_ST_MISALIGN;
    end else begin
      trap_cause_o = '0;
    end
  end

  a_we_xor_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rf_we_o && trap_o))
    else $error("wb_stage: register write and trap in the same cycle");

  // Misalign bits set in the LSU must match the address carried down
  a_misalign_adr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ld.bubble && (ld.exc[rv_backend_pkg::EXC_LD_MISALIGN] ||
                   ld.exc[rv_backend_pkg::EXC_ST_MISALIGN])
    |-> ld.memadr[1:0] != 2'b00)
    else $error("wb_stage: misalign flagged on an aligned address");

endmodule

`default_nettype wire

// ==== logic/rv_backend_top.sv ====
`default_nettype none

module rv_backend_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Execute side
  input  logic [rv_backend_pkg::XLEN-1:0]  ex_pc_i,
  input  rv_backend_pkg::insn_u            ex_insn_i,
  input  logic                             ex_bubble_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  ex_r_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  ex_memadr_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  ex_wdata_i,
  input  logic [rv_backend_pkg::EXC_W-1:0] ex_exc_i,
  input  logic                             stall_i,
  output logic                             stall_o,
  output logic                             flush_o,
  // Register file write port
  output logic                             rf_we_o,
  output logic [4:0]                       rf_waddr_o,
  output logic [rv_backend_pkg::XLEN-1:0]  rf_wdata_o,
  // Trap report
  output logic                             trap_o,
  output logic [rv_backend_pkg::XLEN-1:0]  trap_pc_o,
  output logic [rv_backend_pkg::XLEN-1:0]  trap_cause_o,
  // Data bus
  output logic                             dbus_req_o,
  output logic                             dbus_we_o,
  output logic [rv_backend_pkg::XLEN-1:0]  dbus_adr_o,
  output logic [3:0]                       dbus_be_o,
  output logic [rv_backend_pkg::XLEN-1:0]  dbus_wdata_o,
  input  logic                             dbus_ack_i,
  input  logic [rv_backend_pkg::XLEN-1:0]  dbus_rdata_i
);

  logic                             stall;
  logic                             flush;
  logic                             lsu_busy;
  logic [rv_backend_pkg::EXC_W-1:0] lsu_exc;
  logic [rv_backend_pkg::XLEN-1:0]  lsu_ldata;

  // Memory stage to write-back
  stage_if st_if ();

  // One stall for every stage register
  assign stall   = stall_i | lsu_busy;
  assign stall_o = stall;
  assign flush_o = flush;

  mem_stage u_mem_stage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stall_i  (stall),
    .pc_i     (ex_pc_i),
    .r_i      (ex_r_i),
    .memadr_i (ex_memadr_i),
    .insn_i   (ex_insn_i),
    .bubble_i (ex_bubble_i),
    .exc_dn_i (lsu_exc),
    .flush_i  (flush),
    .st       (st_if.src)
  );

  // Works on the execute-side instruction before the memory stage takes it
  load_store_unit u_lsu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (ex_insn_i),
    .bubble_i     (ex_bubble_i),
    .exc_i        (ex_exc_i),
    .adr_i        (ex_memadr_i),
    .wdata_i      (ex_wdata_i),
    .flush_i      (flush),
    .busy_o       (lsu_busy),
    .exc_o        (lsu_exc),
    .ldata_o      (lsu_ldata),
    .dbus_req_o   (dbus_req_o),
    .dbus_we_o    (dbus_we_o),
    .dbus_adr_o   (dbus_adr_o),
    .dbus_be_o    (dbus_be_o),
    .dbus_wdata_o (dbus_wdata_o),
    .dbus_ack_i   (dbus_ack_i),
    .dbus_rdata_i (dbus_rdata_i)
  );

  wb_stage u_wb_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ld           (st_if.dst),
    .ldata_i      (lsu_ldata),
    .stall_i      (stall),
    .rf_we_o      (rf_we_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_wdata_o   (rf_wdata_o),
    .flush_o      (flush),
    .trap_o       (trap_o),
    .trap_pc_o    (trap_pc_o),
    .trap_cause_o (trap_cause_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

// Free-running testbench clock, 4 ns period
module tb_clock_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
  end

  // Half period
  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== testbench/rv_backend_tb.sv ====
`default_nettype none

module rv_backend_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT = 200;

  logic                  clk;
  logic                  rst_ni;
  logic [31:0]           ex_pc_i;
  rv_backend_pkg::insn_u ex_insn_i;
  logic                  ex_bubble_i;
  logic [31:0]           ex_r_i;
  logic [31:0]           ex_memadr_i;
  logic [31:0]           ex_wdata_i;
  logic [2:0]            ex_exc_i;
  logic                  stall_i;
  logic                  stall_o;
  logic                  flush_o;
  logic                  rf_we_o;
  logic [4:0]            rf_waddr_o;
  logic [31:0]           rf_wdata_o;
  logic                  trap_o;
  logic [31:0]           trap_pc_o;
  logic [31:0]           trap_cause_o;
  logic                  dbus_req_o;
  logic                  dbus_we_o;
  logic [31:0]           dbus_adr_o;
  logic [3:0]            dbus_be_o;
  logic [31:0]           dbus_wdata_o;
  logic                  dbus_ack_i;
  logic [31:0]           dbus_rdata_i;

  // Responder memory and the expected copy of it
  logic [31:0] mem [0:255];
  logic [31:0] exp_mem [0:255];
  integer      seed;
  logic [1:0]  rsp_state;
  logic [31:0] rsp_cnt;
  int          lane;
  logic        stall_en;
  logic [31:0] pc_next;
  int          req_cnt;
  int          flush_cnt;
  // {rd, data} per write, {pc, cause} per trap
  logic [63:0] wr_q[$];
  logic [63:0] exp_wr_q[$];
  logic [63:0] trap_q[$];

  tb_clock_gen u_clk (
    .clk_o (clk)
  );

  rv_backend_top uut (
    .clk_i        (clk),
    .rst_ni       (rst_ni),
    .ex_pc_i      (ex_pc_i),
    .ex_insn_i    (ex_insn_i),
    .ex_bubble_i  (ex_bubble_i),
    .ex_r_i       (ex_r_i),
    .ex_memadr_i  (ex_memadr_i),
    .ex_wdata_i   (ex_wdata_i),
    .ex_exc_i     (ex_exc_i),
    .stall_i      (stall_i),
    .stall_o      (stall_o),
    .flush_o      (flush_o),
    .rf_we_o      (rf_we_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_wdata_o   (rf_wdata_o),
    .trap_o       (trap_o),
    .trap_pc_o    (trap_pc_o),
    .trap_cause_o (trap_cause_o),
    .dbus_req_o   (dbus_req_o),
    .dbus_we_o    (dbus_we_o),
    .dbus_adr_o   (dbus_adr_o),
    .dbus_be_o    (dbus_be_o),
    .dbus_wdata_o (dbus_wdata_o),
    .dbus_ack_i   (dbus_ack_i),
    .dbus_rdata_i (dbus_rdata_i)
  );

  //////////////////////////////////////////////////
  // Bus responder and monitors
  //////////////////////////////////////////////////

  // Four-phase slave, random ack delay of 0 to 3 cycles
  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dbus_ack_i <= 1'b0;
      rsp_state  <= 2'd0;
      rsp_cnt    <= '0;
    end else begin
      case (rsp_state)
        2'd0: begin
          if (dbus_req_o && !dbus_ack_i) begin
            rsp_cnt   <= $random(seed) & 3;
            rsp_state <= 2'd1;
          end
        end
        2'd1: begin
          if (rsp_cnt == 0) begin
            dbus_ack_i <= 1'b1;
            rsp_state  <= 2'd2;
            if (dbus_we_o) begin
              for (lane = 0; lane < 4; lane++) begin
                if (dbus_be_o[lane]) begin
                  mem[dbus_adr_o[9:2]][lane*8 +: 8] <= dbus_wdata_o[lane*8 +: 8];
                end
              end
            end else begin
              dbus_rdata_i <= mem[dbus_adr_o[9:2]];
            end
          end else begin
            rsp_cnt <= rsp_cnt - 1;
          end
        end
        default: begin
          // Ack falls once req is gone
          if (!dbus_req_o) begin
            dbus_ack_i <= 1'b0;
            rsp_state  <= 2'd0;
          end
        end
      endcase
    end
  end

  // Random external stall when enabled
  always @(posedge clk) begin
    if (stall_en) begin
      stall_i <= (($random(seed) & 3) == 0);
    end
  end

  // Writes counted once, at the cycle write-back moves on
  always @(negedge clk) begin
    if (rst_ni) begin
      if (rf_we_o && !stall_o) begin
        wr_q.push_back({27'd0, rf_waddr_o, rf_wdata_o});
      end
      if (trap_o) begin
        trap_q.push_back({trap_pc_o, trap_cause_o});
      end
      if (flush_o) begin
        flush_cnt = flush_cnt + 1;
      end
      if (dbus_req_o) begin
        req_cnt = req_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR: %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  // Memory fill, every byte depends on the full word index
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'hA5, ~a, a + 8'h3C, {a[6:0], a[7]}};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {12'h000, 5'd1, f3, rd, opc};
  endfunction

  // imm_lo shares its bits with rd of the I-type view
  function automatic logic [31:0] enc_s(input logic [2:0] f3);
    return {7'h00, 5'd2, 5'd1, f3, 5'd12, rv_backend_pkg::OPC_STORE};
  endfunction

  // Load result from the expected memory, by RISC-V size and sign rules
  function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] adr);
    logic [31:0] sh;
    sh = exp_mem[adr[9:2]] >> {adr[1:0], 3'b000};
    case (f3)
      rv_backend_pkg::F3_B:  return {{24{sh[7]}}, sh[7:0]};
      rv_backend_pkg::F3_BU: return {24'd0, sh[7:0]};
      rv_backend_pkg::F3_H:  return {{16{sh[15]}}, sh[15:0]};
      rv_backend_pkg::F3_HU: return {16'd0, sh[15:0]};
      default:               return exp_mem[adr[9:2]];
    endcase
  endfunction

  // Present one instruction, return after the edge that takes it
  task automatic issue(input logic [31:0] insn, input logic bubble, input logic [31:0] r,
                       input logic [31:0] adr, input logic [31:0] wdata, input logic [2:0] exc);
    int   n;
    logic done;
    ex_pc_i     <= pc_next;
    ex_insn_i   <= insn;
    ex_bubble_i <= bubble;
    ex_r_i      <= r;
    ex_memadr_i <= adr;
    ex_wdata_i  <= wdata;
    ex_exc_i    <= exc;
    pc_next = pc_next + 4;
    done = 1'b0;
    n = 0;
    while (!done) begin
      @(negedge clk);
      if (!stall_o) begin
        done = 1'b1;
      end
      @(posedge clk);
      n = n + 1;
      if (!done && n >= TIMEOUT) begin
        fail_now("Timeout: the DUT never took the instruction at the execute side");
      end
    end
  endtask

  task automatic bubbles(input int n);
    for (int i = 0; i < n; i++) begin
      issue(32'd0, 1'b1, 32'd0, 32'd0, 32'd0, 3'd0);
    end
  endtask

  task automatic alu(input logic [6:0] opc, input logic [4:0] rd, input logic [31:0] r);
    issue(enc_i(opc, 3'd0, rd), 1'b0, r, 32'd0, 32'd0, 3'd0);
    if (rd != 5'd0) begin
      exp_wr_q.push_back({27'd0, rd, r});
    end
  endtask

  task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [31:0] adr);
    issue(enc_i(rv_backend_pkg::OPC_LOAD, f3, rd), 1'b0, 32'd0, adr, 32'd0, 3'd0);
    exp_wr_q.push_back({27'd0, rd, load_value(f3, adr)});
  endtask

  task automatic store(input logic [2:0] f3, input logic [31:0] adr, input logic [31:0] wd);
    issue(enc_s(f3), 1'b0, 32'd0, adr, wd, 3'd0);
    case (f3)
      rv_backend_pkg::F3_B: exp_mem[adr[9:2]][{adr[1:0], 3'b000} +: 8] = wd[7:0];
      rv_backend_pkg::F3_H: exp_mem[adr[9:2]][{adr[1:0], 3'b000} +: 16] = wd[15:0];
      default:              exp_mem[adr[9:2]] = wd;
    endcase
  endtask

  // Drain the pipe, then compare observed writes with expected ones
  task automatic compare_writes(input string what);
    bubbles(6);
    check_eq({what, ": write count"}, 64'(wr_q.size()), 64'(exp_wr_q.size()));
    foreach (exp_wr_q[i]) begin
      check_eq({what, ": register write"}, wr_q[i], exp_wr_q[i]);
    end
    wr_q.delete();
    exp_wr_q.delete();
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic alu_writeback();
    for (int i = 0; i < 8; i++) begin
      alu((i % 2 == 0) ? rv_backend_pkg::OPC_OP : rv_backend_pkg::OPC_OP_IMM,
          5'(7 - i), 32'h1000_0000 + 32'(i) * 32'h111);
    end
    compare_writes("alu");
  endtask

  task automatic load_extension();
    for (int off = 0; off < 4; off++) begin
      load(rv_backend_pkg::F3_B, 5'(off + 1), 32'h40 + 32'(off));
      load(rv_backend_pkg::F3_BU, 5'(off + 5), 32'h44 + 32'(off));
    end
    for (int off = 0; off < 4; off += 2) begin
      load(rv_backend_pkg::F3_H, 5'(off + 10), 32'hC8 + 32'(off));
      load(rv_backend_pkg::F3_HU, 5'(off + 11), 32'hCC + 32'(off));
    end
    load(rv_backend_pkg::F3_W, 5'd20, 32'h3FC);
    compare_writes("loads");
  endtask

  task automatic store_byte_lanes();
    store(rv_backend_pkg::F3_B, 32'h101, 32'h0000_00E1);
    store(rv_backend_pkg::F3_B, 32'h107, 32'h0000_0072);
    store(rv_backend_pkg::F3_H, 32'h10A, 32'h0000_BEEF);
    store(rv_backend_pkg::F3_W, 32'h10C, 32'hCAFE_F00D);
    // Stores never write a register
    compare_writes("stores");
    for (int i = 'h40; i < 'h44; i++) begin
      check_eq("store memory word", 64'(mem[i]), 64'(exp_mem[i]));
      load(rv_backend_pkg::F3_W, 5'(i - 'h40 + 1), 32'(i) << 2);
    end
    compare_writes("store read-back");
  endtask

  // One excepting instruction followed by an ALU op that must die
  task automatic trap_case(input logic [31:0] insn, input logic [31:0] adr,
                           input logic [2:0] exc, input logic [31:0] cause);
    logic [31:0] pc;
    pc = pc_next;
    req_cnt = 0;
    flush_cnt = 0;
    trap_q.delete();
    issue(insn, 1'b0, 32'd0, adr, 32'h5555_AAAA, exc);
    issue(enc_i(rv_backend_pkg::OPC_OP, 3'd0, 5'd9), 1'b0, 32'h1234_5678, 32'd0, 32'd0, 3'd0);
    compare_writes("trap shadow");
    check_eq("bus requests", 64'(req_cnt), 64'd0);
    check_eq("trap count", 64'(trap_q.size()), 64'd1);
    check_eq("flush cycles", 64'(flush_cnt), 64'd1);
    check_eq("trap pc and cause", trap_q[0], {pc, cause});
  endtask

  task automatic misaligned_traps();
    trap_case(enc_i(rv_backend_pkg::OPC_LOAD, rv_backend_pkg::F3_W, 5'd3), 32'h102, 3'd0,
              rv_backend_pkg::CAUSE_LD_MISALIGN);
    trap_case(enc_s(rv_backend_pkg::F3_H), 32'h105, 3'd0, rv_backend_pkg::CAUSE_ST_MISALIGN);
    trap_case(enc_i(rv_backend_pkg::OPC_OP, 3'd0, 5'd4), 32'd0, 3'b001,
              rv_backend_pkg::CAUSE_ILLEGAL);
  endtask

  task automatic backpressure_stream();
    logic [31:0] rnd;
    logic [2:0]  f3;
    stall_en <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        alu(rv_backend_pkg::OPC_OP_IMM, rnd[12:8], $random(seed));
      end else begin
        case (rnd[3:1] % 5)
          3'd0:    f3 = rv_backend_pkg::F3_B;
          3'd1:    f3 = rv_backend_pkg::F3_BU;
          3'd2:    f3 = rv_backend_pkg::F3_H;
          3'd3:    f3 = rv_backend_pkg::F3_HU;
          default: f3 = rv_backend_pkg::F3_W;
        endcase
        // Offset kept aligned to the access size
        load(f3, rnd[12:8] | 5'd1, {22'd0, rnd[23:16],
             (f3 == rv_backend_pkg::F3_W) ? 2'b00 :
             (f3[0] ? {rnd[24], 1'b0} : rnd[25:24])});
      end
    end
    stall_en <= 1'b0;
    @(posedge clk);
    stall_i <= 1'b0;
    compare_writes("back-pressure");
  endtask

  initial begin
    seed = 32'h4f599699;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i[7:0]);
      exp_mem[i] = fill_word(i[7:0]);
    end
    rst_ni       = 1'b0;
    ex_pc_i      = 32'd0;
    ex_insn_i    = 32'd0;
    ex_bubble_i  = 1'b1;
    ex_r_i       = 32'd0;
    ex_memadr_i  = 32'd0;
    ex_wdata_i   = 32'd0;
    ex_exc_i     = 3'd0;
    stall_i      = 1'b0;
    dbus_rdata_i = 32'd0;
    stall_en     = 1'b0;
    pc_next      = 32'h1000;
    req_cnt      = 0;
    flush_cnt    = 0;
    repeat (2) @(posedge clk);
    rst_ni <= 1'b1;
    @(posedge clk);
    alu_writeback();
    load_extension();
    store_byte_lanes();
    misaligned_traps();
    backpressure_stream();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/rv_backend_pkg.sv
logic/stage_if.sv
logic/mem_stage.sv
logic/load_store_unit.sv
logic/wb_stage.sv
logic/rv_backend_top.sv
testbench/tb_clock_gen.sv
testbench/rv_backend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_backend_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
